// File: logic/core_selector.sv
`timescale 1ns/1ps
`include "sched_cfg.svh"

module core_selector (
  input  sched_core_pkg::slot_cnt_t [`SCHED_CORES-1:0] counts,
  input  logic [`SCHED_CORES-1:0]                      allowed,
  output sched_core_pkg::core_id_t                     core,
  output logic                                         found
);

  localparam int CORES = `SCHED_CORES;

  typedef struct packed {
    logic                      ok;
    sched_core_pkg::slot_cnt_t cnt;
    sched_core_pkg::core_id_t  idx;
  } cand_t;

  // Heap ordered tree, leaves start at CORES-1
  cand_t node [2*CORES-1];

  always_comb begin
    for (int i = 0; i < CORES; i++) begin
      node[CORES-1+i].ok  = allowed[i] && (counts[i] != '0);
      node[CORES-1+i].cnt = counts[i];
      node[CORES-1+i].idx = sched_core_pkg::core_id_t'(i);
    end
    for (int n = CORES - 2; n >= 0; n--) begin
      // Left child covers the lower indices and keeps ties
      if (node[2*n+2].ok && (!node[2*n+1].ok || (node[2*n+2].cnt > node[2*n+1].cnt))) begin
        node[n] = node[2*n+2];
      end else begin
        node[n] = node[2*n+1];
      end
    end
  end

  assign core  = node[0].idx;
  assign found = node[0].ok;

endmodule

// File: logic/desc_arbiter.sv
`timescale 1ns/1ps
`include "sched_cfg.svh"

module desc_arbiter (
  input  logic                         clk,
  input  logic                         rst_r,
  input  logic [`SCHED_PORTS-1:0]      req,
  input  logic                         take,
  output logic [`SCHED_PORTS-1:0]      grant,
  output sched_core_pkg::port_id_t     grant_port
);

  localparam int PORTS = `SCHED_PORTS;

  // First port to consider this cycle
  sched_core_pkg::port_id_t prio;

  always_comb begin
    int idx;
    grant      = '0;
    grant_port = '0;
    // Walk downwards so the port closest to prio is written last
    for (int k = PORTS - 1; k >= 0; k--) begin
      idx = (int'(prio) + k) % PORTS;
      if (req[idx]) begin
        grant      = '0;
        grant[idx] = 1'b1;
        grant_port = sched_core_pkg::port_id_t'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      prio <= '0;
    end else if (take && (|grant)) begin
      prio <= (int'(grant_port) == PORTS - 1) ? '0 : grant_port + 1'b1;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst_r)
    $onehot0(grant));

endmodule

// File: logic/packet_scheduler.sv
`timescale 1ns/1ps
`include "sched_cfg.svh"

module packet_scheduler (
  input  logic                                         clk,
  input  logic                                         rst_r,
  input  sched_stream_pkg::beat_t [`SCHED_PORTS-1:0]   rx_beat,
  input  logic [`SCHED_PORTS-1:0]                      rx_valid,
  output logic [`SCHED_PORTS-1:0]                      rx_ready,
  output sched_stream_pkg::beat_t [`SCHED_PORTS-1:0]   out_beat,
  output sched_core_pkg::dest_t [`SCHED_PORTS-1:0]     out_dest,
  output sched_core_pkg::port_id_t [`SCHED_PORTS-1:0]  out_port,
  output logic [`SCHED_PORTS-1:0]                      out_valid,
  input  logic [`SCHED_PORTS-1:0]                      out_ready,
  input  sched_stream_pkg::ctrl_msg_t                  ctrl_msg,
  input  logic                                         ctrl_valid,
  output logic                                         ctrl_ready,
  input  logic [`SCHED_CORES-1:0]                      income_cores
);

  localparam int PORTS = `SCHED_PORTS;
  localparam int CORES = `SCHED_CORES;

  logic [CORES-1:0]                      init_v;
  logic [CORES-1:0]                      ret_v;
  logic [CORES-1:0]                      pop_core;
  sched_core_pkg::slot_t                 msg_slot_r;
  sched_core_pkg::slot_cnt_t [CORES-1:0] counts;
  sched_core_pkg::slot_t [CORES-1:0]     heads;
  sched_core_pkg::core_id_t              sel_core;
  logic                                  found;
  logic [PORTS-1:0]                      desc_req;
  logic [PORTS-1:0]                      grant;
  logic [PORTS-1:0]                      desc_load;
  logic [PORTS-1:0]                      loaded_r;
  logic [PORTS-1:0]                      open;
  sched_core_pkg::port_id_t              grant_port;
  logic                                  pop;
  sched_core_pkg::dest_t                 new_dest;

  // Slot messages never back-pressure
  assign ctrl_ready = 1'b1;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_v <= '0;
      ret_v  <= '0;
    end else begin
      for (int c = 0; c < CORES; c++) begin
        init_v[c] <= ctrl_valid && (ctrl_msg.src == sched_core_pkg::core_id_t'(c)) &&
                     (ctrl_msg.msg_type == sched_stream_pkg::SLOT_INIT);
        ret_v[c]  <= ctrl_valid && (ctrl_msg.src == sched_core_pkg::core_id_t'(c)) &&
                     (ctrl_msg.msg_type == sched_stream_pkg::SLOT_RETURN);
      end
    end
  end

  always_ff @(posedge clk) begin
    msg_slot_r <= ctrl_msg.slot;
  end

  for (genvar c = 0; c < CORES; c++) begin : g_core
    assign pop_core[c] = pop && (sel_core == sched_core_pkg::core_id_t'(c));

    slot_keeper u_keeper (
      .clk        (clk),
      .rst_r      (rst_r),
      .init_valid (init_v[c]),
      .init_count (msg_slot_r),
      .ret_valid  (ret_v[c]),
      .ret_slot   (msg_slot_r),
      .pop        (pop_core[c]),
      .head_slot  (heads[c]),
      .count      (counts[c])
    );
  end

  core_selector u_selector (
    .counts  (counts),
    .allowed (income_cores),
    .core    (sel_core),
    .found   (found)
  );

  desc_arbiter u_arbiter (
    .clk        (clk),
    .rst_r      (rst_r),
    .req        (desc_req),
    .take       (pop),
    .grant      (grant),
    .grant_port (grant_port)
  );

  assign pop           = (|grant) && found;
  assign new_dest.core = sel_core;
  assign new_dest.slot = heads[sel_core];

  // A port that just took a descriptor sits out one request cycle
  always_ff @(posedge clk) begin
    if (rst_r) begin
      loaded_r <= '0;
    end else begin
      loaded_r <= desc_load;
    end
  end

  for (genvar p = 0; p < PORTS; p++) begin : g_port
    assign desc_load[p] = pop && (grant_port == sched_core_pkg::port_id_t'(p));

    port_fsm u_port (
      .clk       (clk),
      .rst_r     (rst_r),
      .rx_valid  (rx_valid[p]),
      .out_ready (out_ready[p]),
      .granted   (loaded_r[p]),
      .desc_load (desc_load[p]),
      .new_dest  (new_dest),
      .last      (rx_beat[p].last),
      .desc_req  (desc_req[p]),
      .open      (open[p]),
      .dest      (out_dest[p])
    );

    assign out_beat[p]  = rx_beat[p];
    assign out_valid[p] = rx_valid[p] && open[p];
    assign rx_ready[p]  = out_ready[p] && open[p];
    assign out_port[p]  = sched_core_pkg::port_id_t'(p);
  end

endmodule

// File: logic/port_fsm.sv
`timescale 1ns/1ps

module port_fsm (
  input  logic                        clk,
  input  logic                        rst_r,
  input  logic                        rx_valid,
  input  logic                        out_ready,
  input  logic                        granted,
  input  logic                        desc_load,
  input  sched_core_pkg::dest_t       new_dest,
  input  logic                        last,
  output logic                        desc_req,
  output logic                        open,
  output sched_core_pkg::dest_t       dest
);

  sched_core_pkg::port_state_e state;
  sched_core_pkg::dest_t       pend;
  sched_core_pkg::dest_t       cur;
  logic                        xfer;
  logic                        eop;

  assign open = (state != sched_core_pkg::STALL);
  assign xfer = rx_valid && out_ready && open;
  assign eop  = xfer && last;

  // First beat goes out with the pending descriptor, the rest with the latched one
  assign dest = (state == sched_core_pkg::FIRST) ? pend : cur;

  assign desc_req = !granted && ((state == sched_core_pkg::STALL) ||
                                 (state == sched_core_pkg::WAIT) ||
                                 ((state == sched_core_pkg::FIRST) && xfer));

  always_ff @(posedge clk) begin
    if (rst_r) begin
      state <= sched_core_pkg::STALL;
    end else begin
      case (state)
        sched_core_pkg::STALL: begin
          if (desc_load) begin
            state <= sched_core_pkg::FIRST;
          end
        end
        sched_core_pkg::FIRST: begin
          if (eop) begin
            state <= desc_load ? sched_core_pkg::FIRST : sched_core_pkg::STALL;
          end else if (xfer) begin
            state <= desc_load ? sched_core_pkg::MID : sched_core_pkg::WAIT;
          end
        end
        sched_core_pkg::WAIT: begin
          if (desc_load && eop) begin
            state <= sched_core_pkg::FIRST;
          end else if (desc_load) begin
            state <= sched_core_pkg::MID;
          end else if (eop) begin
            state <= sched_core_pkg::STALL;
          end
        end
        default: begin
          if (eop) begin
            state <= sched_core_pkg::FIRST;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (desc_load) begin
      pend <= new_dest;
    end
    if ((state == sched_core_pkg::FIRST) && xfer) begin
      cur <= pend;
    end
  end

  // tdest holds for every beat of a packet
  a_dest_stable: assert property (@(posedge clk) disable iff (rst_r)
    (xfer && !last) |=> (dest == $past(dest)));

endmodule

// File: logic/sched_cfg.svh
`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

// Receive ports feeding the scheduler
`define SCHED_PORTS 2

// Cores behind the scheduler, kept a power of two for the compare tree
`define SCHED_CORES 4

// Packet slots each core can hold
`define SCHED_SLOTS 8

// Stream data width in bits
`define SCHED_DATA_W 64

`endif

// File: logic/sched_core_pkg.sv
`include "sched_cfg.svh"

package sched_core_pkg;

  typedef logic [$clog2(`SCHED_CORES)-1:0] core_id_t;

  // Slots count from 1, so zero never names a slot
  typedef logic [$clog2(`SCHED_SLOTS+1)-1:0] slot_t;

  // Free slot count, 0 up to SCHED_SLOTS
  typedef logic [$clog2(`SCHED_SLOTS+1)-1:0] slot_cnt_t;

  typedef logic [$clog2(`SCHED_PORTS)-1:0] port_id_t;

  // Carried as tdest on the core-bound stream
  typedef struct packed {
    core_id_t core;
    slot_t    slot;
  } dest_t;

  typedef enum logic [1:0] {
    STALL = 2'd0,
    FIRST = 2'd1,
    WAIT  = 2'd2,
    MID   = 2'd3
  } port_state_e;

endpackage

// File: logic/sched_stream_pkg.sv
`include "sched_cfg.svh"

package sched_stream_pkg;

  typedef struct packed {
    logic [`SCHED_DATA_W-1:0]   data;
    logic [`SCHED_DATA_W/8-1:0] keep;
    logic                       last;
  } beat_t;

  // Types 1 and 2 exist on the bus but are not handled here
  typedef enum logic [3:0] {
    SLOT_RETURN = 4'd0,
    SLOT_INIT   = 4'd3
  } msg_type_e;

  // Slot is the returned slot, or the slot count for an init
  typedef struct packed {
    msg_type_e                msg_type;
    sched_core_pkg::slot_t    slot;
    sched_core_pkg::core_id_t src;
  } ctrl_msg_t;

endpackage

// File: logic/slot_keeper.sv
`timescale 1ns/1ps
`include "sched_cfg.svh"

module slot_keeper (
  input  logic                      clk,
  input  logic                      rst_r,
  input  logic                      init_valid,
  input  sched_core_pkg::slot_cnt_t init_count,
  input  logic                      ret_valid,
  input  sched_core_pkg::slot_t     ret_slot,
  input  logic                      pop,
  output sched_core_pkg::slot_t     head_slot,
  output sched_core_pkg::slot_cnt_t count
);

  localparam int SLOTS = `SCHED_SLOTS;
  localparam int PTR_W = $clog2(SLOTS);

  sched_core_pkg::slot_t     mem [SLOTS];
  logic [PTR_W-1:0]          rd_ptr;
  logic [PTR_W-1:0]          wr_ptr;
  sched_core_pkg::slot_cnt_t load_count;

  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
    if (int'(ptr) == SLOTS - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Init counts beyond the store size are clipped
  assign load_count = (init_count > SLOTS) ? sched_core_pkg::slot_cnt_t'(SLOTS) : init_count;

  assign head_slot = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= (int'(load_count) == SLOTS) ? '0 : load_count[PTR_W-1:0];
      count  <= load_count;
    end else begin
      if (ret_valid) begin
        wr_ptr <= bump(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= bump(rd_ptr);
      end
      if (ret_valid && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !ret_valid) begin
        count <= count - 1'b1;
      end
    end
  end

  // Init refills the whole ring with 1..SLOTS, only count of them are live
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < SLOTS; i++) begin
        mem[i] <= sched_core_pkg::slot_t'(i + 1);
      end
    end else if (ret_valid) begin
      mem[wr_ptr] <= ret_slot;
    end
  end

  // A core never returns more slots than it was given
  a_no_ret_full: assert property (@(posedge clk) disable iff (rst_r)
    (ret_valid && !init_valid && !pop) |-> (int'(count) < SLOTS));

  // The selector only picks a core that holds a free slot
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_r)
    pop |-> (count != '0));

  a_count_range: assert property (@(posedge clk) disable iff (rst_r)
    int'(count) <= SLOTS);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module sched_tb -o sched_sim \
  && ./obj_dir/sched_sim | tee /dev/stderr | grep -q "^NO ERRORS$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim.f
+incdir+logic
+incdir+testbench
logic/sched_core_pkg.sv
logic/sched_stream_pkg.sv
logic/slot_keeper.sv
logic/core_selector.sv
logic/desc_arbiter.sv
logic/port_fsm.sv
logic/packet_scheduler.sv
testbench/sched_tb.sv

// File: testbench/sched_model.svh
`ifndef SCHED_MODEL_SVH
`define SCHED_MODEL_SVH

// Free slots of each core, one bit per slot number
logic [`SCHED_SLOTS:0] free_map [`SCHED_CORES];

// Slot order inside each keeper, used to predict the next pick
sched_core_pkg::slot_t keep_q [`SCHED_CORES][$];

// Slots of finished packets, waiting to be handed back
sched_core_pkg::dest_t used_q [$];

// Beats driven on each rx port and not yet seen at the output
sched_stream_pkg::beat_t exp_beats [`SCHED_PORTS][$];

function automatic void model_init(input int core, input int n);
  free_map[core] = '0;
  keep_q[core].delete();
  for (int s = 1; s <= n; s++) begin
    free_map[core][s] = 1'b1;
    keep_q[core].push_back(sched_core_pkg::slot_t'(s));
  end
endfunction

// Removes a slot that the DUT handed out, false if it was not free
function automatic bit model_take(input sched_core_pkg::dest_t d);
  if (!free_map[d.core][d.slot]) begin
    return 1'b0;
  end
  free_map[d.core][d.slot] = 1'b0;
  return 1'b1;
endfunction

function automatic void model_return(input sched_core_pkg::dest_t d);
  free_map[d.core][d.slot] = 1'b1;
  keep_q[d.core].push_back(d.slot);
endfunction

function automatic int free_total();
  int n;
  n = 0;
  for (int c = 0; c < `SCHED_CORES; c++) begin
    n += $countones(free_map[c]);
  end
  return n;
endfunction

// Allowed core with the most slots left in its keeper, lowest index on ties
function automatic void model_pick(input logic [`SCHED_CORES-1:0] mask, output bit ok,
                                   output sched_core_pkg::dest_t d);
  int best;
  best = -1;
  d = '0;
  for (int c = 0; c < `SCHED_CORES; c++) begin
    if (mask[c] && keep_q[c].size() > 0 &&
        (best < 0 || keep_q[c].size() > keep_q[best].size())) begin
      best = c;
    end
  end
  ok = (best >= 0);
  if (ok) begin
    d.core = sched_core_pkg::core_id_t'(best);
    d.slot = keep_q[best].pop_front();
  end
endfunction

`endif

// File: testbench/sched_tb.sv
`timescale 1ns/1ps
`include "sched_cfg.svh"

module sched_tb;

  localparam int PORTS = `SCHED_PORTS;
  localparam int CORES = `SCHED_CORES;
  // Rough count of beats over all tests, sets the watchdog
  localparam int BEAT_BUDGET = 300;

  logic                                        clk = 1'b0;
  logic                                        rst_r;
  sched_stream_pkg::beat_t [PORTS-1:0]         rx_beat;
  logic [PORTS-1:0]                            rx_valid;
  logic [PORTS-1:0]                            rx_ready;
  sched_stream_pkg::beat_t [PORTS-1:0]         out_beat;
  sched_core_pkg::dest_t [PORTS-1:0]           out_dest;
  sched_core_pkg::port_id_t [PORTS-1:0]        out_port;
  logic [PORTS-1:0]                            out_valid;
  logic [PORTS-1:0]                            out_ready;
  sched_stream_pkg::ctrl_msg_t                 ctrl_msg;
  logic                                        ctrl_valid;
  logic                                        ctrl_ready;
  logic [CORES-1:0]                            income_cores;

  logic [31:0]           lfsr = 32'h26d;
  int                    errors = 0;
  int                    checks = 0;
  int                    test_errs = 0;
  int                    ntests = 0;
  bit                    stall_mode = 0;
  bit                    choice_mode = 0;
  bit                    bp_on = 0;
  bit                    recycle_on = 0;
  bit                    in_pkt [PORTS];
  bit                    exempt [PORTS];
  bit                    exp_valid [PORTS];
  sched_core_pkg::dest_t exp_dest [PORTS];
  sched_core_pkg::dest_t pkt_dest [PORTS];

  `include "sched_model.svh"

  packet_scheduler uut (.*);

  always #50 clk = ~clk;

  initial begin
    #(BEAT_BUDGET * 20 * 100);
    $display("watchdog expired after %0d cycles, traffic got stuck", BEAT_BUDGET * 20);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic sched_stream_pkg::beat_t random_beat(input logic last);
    sched_stream_pkg::beat_t b;
    b.data = {rand_bits(32), rand_bits(32)};
    b.keep = rand_bits(8);
    b.last = last;
    return b;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_fail(input string what);
    errors++;
    $display("failure at %0t: %s", $time, what);
  endtask

  task automatic end_test(input string name);
    // Every accepted beat must have left the DUT by now
    for (int p = 0; p < PORTS; p++) begin
      if (exp_beats[p].size() != 0) begin
        report_fail($sformatf("port %0d accepted %0d beats that never came out", p,
                              exp_beats[p].size()));
        exp_beats[p].delete();
      end
    end
    $display("test %s done with %0d errors", name, errors - test_errs);
    test_errs = errors;
    ntests++;
  endtask

  task automatic observe_beat(input int p);
    sched_stream_pkg::beat_t exp;
    sched_core_pkg::dest_t   d;
    d = out_dest[p];
    check_val($sformatf("rx_ready[%0d]", p), rx_ready[p], 1);
    if (exp_beats[p].size() == 0) begin
      report_fail($sformatf("port %0d sent a beat that was never driven", p));
      return;
    end
    exp = exp_beats[p].pop_front();
    check_val($sformatf("out_beat[%0d].data", p), out_beat[p].data, exp.data);
    check_val($sformatf("out_beat[%0d].keep", p), out_beat[p].keep, exp.keep);
    check_val($sformatf("out_beat[%0d].last", p), out_beat[p].last, exp.last);
    check_val($sformatf("out_port[%0d]", p), out_port[p], p);
    if (!in_pkt[p]) begin
      if (exp_valid[p]) begin
        check_val($sformatf("out_dest[%0d]", p), d, exp_dest[p]);
        exp_valid[p] = 0;
      end
      if (!model_take(d)) begin
        report_fail($sformatf("slot %0d of core %0d given out while not free", d.slot, d.core));
      end
      if (!income_cores[d.core] && !exempt[p]) begin
        report_fail($sformatf("port %0d got masked core %0d", p, d.core));
      end
      exempt[p] = 0;
      if (choice_mode && p == 0) begin
        model_pick(income_cores, exp_valid[0], exp_dest[0]);
      end
      pkt_dest[p] = d;
      in_pkt[p] = 1;
    end else begin
      check_val($sformatf("out_dest[%0d]", p), d, pkt_dest[p]);
    end
    if (exp.last) begin
      in_pkt[p] = 0;
      used_q.push_back(pkt_dest[p]);
    end
  endtask

  // Outputs are settled at the falling edge, a beat moves on the next rising one
  task automatic monitor_loop();
    forever begin
      @(negedge clk);
      for (int p = 0; p < PORTS; p++) begin
        if (!rst_r && stall_mode) begin
          check_val($sformatf("out_valid[%0d]", p), out_valid[p], 0);
          check_val($sformatf("rx_ready[%0d]", p), rx_ready[p], 0);
        end
        if (!rst_r && out_valid[p] && out_ready[p]) begin
          observe_beat(p);
        end
      end
    end
  endtask

  task automatic ready_loop();
    forever begin
      @(posedge clk);
      #1;
      out_ready = bp_on ? PORTS'(rand_bits(PORTS)) : '1;
    end
  endtask

  task automatic wait_accept(input int p, input int limit, output bit ok);
    int n;
    ok = 0;
    n = 0;
    while (!ok && n < limit) begin
      @(negedge clk);
      ok = rx_ready[p];
      @(posedge clk);
      #1;
      n++;
    end
    if (ok) begin
      rx_valid[p] = 1'b0;
    end
  endtask

  task automatic drive_beat(input int p, input sched_stream_pkg::beat_t b, input int limit,
                            output bit ok);
    rx_beat[p] = b;
    rx_valid[p] = 1'b1;
    wait_accept(p, limit, ok);
  endtask

  task automatic send_ctrl(input sched_stream_pkg::msg_type_e t, input int slot, input int core);
    ctrl_msg.msg_type = t;
    ctrl_msg.slot = sched_core_pkg::slot_t'(slot);
    ctrl_msg.src = sched_core_pkg::core_id_t'(core);
    ctrl_valid = 1'b1;
    check_val("ctrl_ready", ctrl_ready, 1);
    @(posedge clk);
    #1;
    ctrl_valid = 1'b0;
  endtask

  task automatic give_back(input sched_core_pkg::dest_t d);
    model_return(d);
    send_ctrl(sched_stream_pkg::SLOT_RETURN, d.slot, d.core);
  endtask

  task automatic run_port(input int p, input int n);
    sched_stream_pkg::beat_t b;
    int len;
    bit ok;
    for (int k = 0; k < n; k++) begin
      len = 1 + int'(rand_bits(2));
      for (int i = 0; i < len; i++) begin
        b = random_beat(i == len - 1);
        exp_beats[p].push_back(b);
        drive_beat(p, b, 400, ok);
        if (!ok) begin
          report_fail($sformatf("port %0d beat was never accepted", p));
          return;
        end
      end
      repeat (int'(rand_bits(2))) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic recycle_loop();
    while (recycle_on) begin
      if (used_q.size() > 0 && rand_bits(2) == 0) begin
        give_back(used_q.pop_front());
      end else begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic run_mixed(input int n);
    recycle_on = 1;
    fork
      begin
        fork
          run_port(0, n);
          run_port(1, n);
        join
        recycle_on = 0;
      end
      recycle_loop();
    join
  endtask

  // Port 0 drains every keeper, then one return must wake it with that slot
  task automatic return_test();
    sched_stream_pkg::beat_t b;
    sched_core_pkg::dest_t   d;
    bit ok;
    int n;
    ok = 1;
    n = 0;
    while (ok && n < 60) begin
      b = random_beat(1'b1);
      exp_beats[0].push_back(b);
      drive_beat(0, b, 20, ok);
      n++;
    end
    if (ok) begin
      report_fail("port 0 never stalled with all slots in use");
      return;
    end
    // Port 1 still holds its spare descriptor
    check_val("free slots", free_total(), 1);
    d = used_q.pop_front();
    exp_dest[0] = d;
    exp_valid[0] = 1;
    give_back(d);
    wait_accept(0, 8, ok);
    if (!ok) begin
      report_fail("port 0 did not resume after a slot return");
      rx_valid[0] = 1'b0;
    end
  endtask

  initial begin
    int cnt;
    logic [31:0] m;
    rst_r = 1'b1;
    rx_beat = '0;
    rx_valid = '0;
    out_ready = '1;
    ctrl_msg = '0;
    ctrl_valid = 1'b0;
    income_cores = '1;
    for (int p = 0; p < PORTS; p++) begin
      in_pkt[p] = 0;
      exempt[p] = 0;
      exp_valid[p] = 0;
    end
    fork
      monitor_loop();
      ready_loop();
    join_none
    repeat (8) @(posedge clk);
    #1;
    rst_r = 1'b0;

    stall_mode = 1;
    repeat (16) begin
      rx_beat[0] = random_beat(rand_bits(1));
      rx_beat[1] = random_beat(rand_bits(1));
      rx_valid = '1;
      @(posedge clk);
      #1;
    end
    rx_valid = '0;
    stall_mode = 0;
    end_test("stall");

    // Fill the keepers while no core is allowed, then both ports pick in turn
    income_cores = '0;
    for (int c = 0; c < CORES; c++) begin
      cnt = 5 + int'(rand_bits(2));
      model_init(c, cnt);
      send_ctrl(sched_stream_pkg::SLOT_INIT, cnt, c);
    end
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    model_pick('1, exp_valid[0], exp_dest[0]);
    model_pick('1, exp_valid[1], exp_dest[1]);
    income_cores = '1;

    choice_mode = 1;
    run_port(0, 6);
    choice_mode = 0;
    end_test("core choice");

    return_test();
    end_test("return");

    run_mixed(5);
    end_test("slot validity");

    bp_on = 1;
    run_mixed(8);
    end_test("integrity");

    m = rand_bits(CORES - 1);
    // Core 0 stays masked since it wins every tie
    income_cores = {m[CORES-2:0], 1'b0};
    if (income_cores == '0) begin
      income_cores = CORES'(2);
    end
    exempt[0] = 1;
    exempt[1] = 1;
    run_mixed(6);
    bp_on = 0;
    end_test("mask");

    $display("tests %0d, checks %0d, errors %0d", ntests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
